//--- project.f
rtl/mac_cfg_pkg.sv
rtl/cfg_cmd_if.sv
rtl/reg_access_if.sv
rtl/mac_phy_init_seq.sv
rtl/mdio_cmd_engine.sv
rtl/axil_master.sv
rtl/mac_cfg_top.sv
verif/mac_cfg_properties.sv
verif/mac_cfg_tb.sv

//--- rtl/axil_master.sv
/* AXI-Lite master running one read or write per register access request */
`timescale 1ns/100ps

module axil_master
(
	input  logic                   s_axi_aclk,
	input  logic                   s_axi_resetn,
	reg_access_if.mst              acc,
	output mac_cfg_pkg::axil_addr_t s_axi_awaddr,
	output logic                   s_axi_awvalid,
	input  logic                   s_axi_awready,
	output mac_cfg_pkg::axil_data_t s_axi_wdata,
	output logic                   s_axi_wvalid,
	input  logic                   s_axi_wready,
	// Responses are taken but not checked
	input  logic [1:0]             s_axi_bresp,
	input  logic                   s_axi_bvalid,
	output logic                   s_axi_bready,
	output mac_cfg_pkg::axil_addr_t s_axi_araddr,
	output logic                   s_axi_arvalid,
	input  logic                   s_axi_arready,
	input  mac_cfg_pkg::axil_data_t s_axi_rdata,
	input  logic [1:0]             s_axi_rresp,
	input  logic                   s_axi_rvalid,
	output logic                   s_axi_rready
);
	import mac_cfg_pkg::*;

	typedef enum logic [1:0] {M_IDLE, M_WRITE, M_READ, M_DONE} mst_state_e;

	mst_state_e state;
	axil_addr_t addr_q;
	axil_data_t wdata_q;
	logic       aw_done;
	logic       w_done;

	// Buses are zero while their valid is low
	assign s_axi_awaddr = s_axi_awvalid ? addr_q : '0;
	assign s_axi_araddr = s_axi_arvalid ? addr_q : '0;
	assign s_axi_wdata  = s_axi_wvalid ? wdata_q : '0;

	// ----------------------------------------------------------------------
	// Channel control
	// ----------------------------------------------------------------------
	always_ff @(posedge s_axi_aclk)
	begin
		if (!s_axi_resetn)
		begin
			state <= M_IDLE;
			s_axi_awvalid <= 1'b0;
			s_axi_wvalid <= 1'b0;
			s_axi_bready <= 1'b0;
			s_axi_arvalid <= 1'b0;
			s_axi_rready <= 1'b0;
			aw_done <= 1'b0;
			w_done <= 1'b0;
			acc.ack <= 1'b0;
		end
		else
		begin
			case (state)
				M_IDLE:
				begin
					if (acc.req)
					begin
						aw_done <= 1'b0;
						w_done <= 1'b0;
						if (acc.write)
						begin
							s_axi_awvalid <= 1'b1;
							s_axi_wvalid <= 1'b1;
							state <= M_WRITE;
						end
						else
						begin
							s_axi_arvalid <= 1'b1;
							state <= M_READ;
						end
					end
				end
				M_WRITE:
				begin
					if (s_axi_awvalid && s_axi_awready)
					begin
						s_axi_awvalid <= 1'b0;
						aw_done <= 1'b1;
					end
					if (s_axi_wvalid && s_axi_wready)
					begin
						s_axi_wvalid <= 1'b0;
						w_done <= 1'b1;
					end
					// Response phase opens once address and data are both taken
					if (aw_done && w_done && !s_axi_bready)
						s_axi_bready <= 1'b1;
					if (s_axi_bready && s_axi_bvalid)
					begin
						s_axi_bready <= 1'b0;
						acc.ack <= 1'b1;
						state <= M_DONE;
					end
				end
				M_READ:
				begin
					if (s_axi_arvalid && s_axi_arready)
					begin
						s_axi_arvalid <= 1'b0;
						s_axi_rready <= 1'b1;
					end
					if (s_axi_rready && s_axi_rvalid)
					begin
						s_axi_rready <= 1'b0;
						acc.ack <= 1'b1;
						state <= M_DONE;
					end
				end
				default:
				begin
					if (!acc.req)
					begin
						acc.ack <= 1'b0;
						state <= M_IDLE;
					end
				end
			endcase
		end
	end

	// Request payload and read data capture
	always_ff @(posedge s_axi_aclk)
	begin
		if (state == M_IDLE && acc.req)
		begin
			addr_q <= acc.addr;
			wdata_q <= acc.wdata;
		end
		if (state == M_READ && s_axi_rready && s_axi_rvalid)
			acc.rdata <= s_axi_rdata;
	end

endmodule

//--- rtl/cfg_cmd_if.sv
/* Command channel from the bring-up sequencer to the MDIO engine */
`timescale 1ns/100ps

interface cfg_cmd_if;
	import mac_cfg_pkg::*;

	logic       req;
	cmd_kind_e  kind;
	axil_addr_t addr;
	phy_reg_t   phy_reg;
	axil_data_t wdata;
	logic       ack;
	// PHY read result, valid while ack is high
	axil_data_t rdata;

	modport seq (
		output req, kind, addr, phy_reg, wdata,
		input  ack, rdata
	);

	modport eng (
		input  req, kind, addr, phy_reg, wdata,
		output ack, rdata
	);

endinterface

//--- rtl/mac_cfg_pkg.sv
/* Shared types, MAC register map, PHY constants, command kinds, speed codes
   and configuration words for the MAC start-up configuration master */
package mac_cfg_pkg;

	typedef logic [11:0] axil_addr_t;
	typedef logic [31:0] axil_data_t;
	typedef logic [4:0]  phy_reg_t;

	typedef enum logic [1:0] {CMD_MAC_WR, CMD_PHY_WR, CMD_PHY_RD} cmd_kind_e;
	typedef enum logic [1:0] {SPEED_10M = 2'd0, SPEED_100M = 2'd1, SPEED_1G = 2'd2} mac_speed_e;

	// ----------------------------------------------------------------------
	// MAC register map
	// ----------------------------------------------------------------------
	localparam axil_addr_t MGMT_CFG_ADDR   = 12'h500;
	localparam axil_addr_t MDIO_CTRL_ADDR  = 12'h504;
	localparam axil_addr_t MDIO_TX_ADDR    = 12'h508;
	localparam axil_addr_t MDIO_RX_ADDR    = 12'h50C;
	localparam axil_addr_t RX_CFG_ADDR     = 12'h404;
	localparam axil_addr_t TX_CFG_ADDR     = 12'h408;
	localparam axil_addr_t FLOW_CFG_ADDR   = 12'h40C;
	localparam axil_addr_t SPEED_CFG_ADDR  = 12'h410;
	localparam axil_addr_t UNI0_ADDR       = 12'h700;
	localparam axil_addr_t UNI1_ADDR       = 12'h704;
	localparam axil_addr_t FILTER_CFG_ADDR = 12'h708;
	localparam axil_addr_t FILTER_EN_ADDR  = 12'h70C;

	// ----------------------------------------------------------------------
	// PHY side
	// ----------------------------------------------------------------------
	localparam logic [4:0] PHY_ADDR         = 5'd7;
	localparam phy_reg_t   PHY_CTRL_REG     = 5'd0;
	localparam phy_reg_t   PHY_STAT_REG     = 5'd1;
	localparam phy_reg_t   PHY_ABILITY_REG  = 5'd4;
	localparam phy_reg_t   PHY_GIG_CTRL_REG = 5'd9;
	localparam logic [1:0] MDIO_OP_WR       = 2'b01;
	localparam logic [1:0] MDIO_OP_RD       = 2'b10;

	// Configuration words
	localparam axil_data_t MDC_DIV_WORD     = 32'h0000_0058;
	localparam axil_data_t MAC_RESET_WORD   = 32'h9000_0000;
	localparam axil_data_t PHY_RESTART_WORD = 32'h0000_9000;
	localparam axil_data_t FILTER_EN_WORD   = 32'h0000_0001;
	localparam axil_data_t UNI0_WORD        = 32'h0135_0A00;
	localparam axil_data_t UNI1_WORD        = 32'h0000_C0FE;

	localparam int MDIO_READY_BIT = 16;
	localparam int AN_DONE_BIT    = 5;

	// Status read of a missing PHY floats high
	localparam logic [16:0] PHY_ABSENT_WORD = 17'h1_FFFF;

	localparam int STARTUP_DELAY = 64;

endpackage

//--- rtl/mac_cfg_top.sv
/* Top level of the MAC start-up configuration master */
`timescale 1ns/100ps

module mac_cfg_top
(
	input  logic                    s_axi_aclk,
	input  logic                    s_axi_resetn,
	input  logic [1:0]              mac_speed,
	output mac_cfg_pkg::axil_addr_t s_axi_awaddr,
	output logic                    s_axi_awvalid,
	input  logic                    s_axi_awready,
	output mac_cfg_pkg::axil_data_t s_axi_wdata,
	output logic                    s_axi_wvalid,
	input  logic                    s_axi_wready,
	input  logic [1:0]              s_axi_bresp,
	input  logic                    s_axi_bvalid,
	output logic                    s_axi_bready,
	output mac_cfg_pkg::axil_addr_t s_axi_araddr,
	output logic                    s_axi_arvalid,
	input  logic                    s_axi_arready,
	input  mac_cfg_pkg::axil_data_t s_axi_rdata,
	input  logic [1:0]              s_axi_rresp,
	input  logic                    s_axi_rvalid,
	output logic                    s_axi_rready,
	output logic                    config_done
);

	cfg_cmd_if    cmd_bus ();
	reg_access_if acc_bus ();

	// Sequencer -> MDIO engine -> AXI-Lite master
	mac_phy_init_seq seq_i (
		.s_axi_aclk   (s_axi_aclk),
		.s_axi_resetn (s_axi_resetn),
		.mac_speed    (mac_speed),
		.cmd          (cmd_bus.seq),
		.config_done  (config_done)
	);

	mdio_cmd_engine eng_i (
		.s_axi_aclk   (s_axi_aclk),
		.s_axi_resetn (s_axi_resetn),
		.cmd          (cmd_bus.eng),
		.acc          (acc_bus.eng)
	);

	axil_master mst_i (
		.s_axi_aclk    (s_axi_aclk),
		.s_axi_resetn  (s_axi_resetn),
		.acc           (acc_bus.mst),
		.s_axi_awaddr  (s_axi_awaddr),
		.s_axi_awvalid (s_axi_awvalid),
		.s_axi_awready (s_axi_awready),
		.s_axi_wdata   (s_axi_wdata),
		.s_axi_wvalid  (s_axi_wvalid),
		.s_axi_wready  (s_axi_wready),
		.s_axi_bresp   (s_axi_bresp),
		.s_axi_bvalid  (s_axi_bvalid),
		.s_axi_bready  (s_axi_bready),
		.s_axi_araddr  (s_axi_araddr),
		.s_axi_arvalid (s_axi_arvalid),
		.s_axi_arready (s_axi_arready),
		.s_axi_rdata   (s_axi_rdata),
		.s_axi_rresp   (s_axi_rresp),
		.s_axi_rvalid  (s_axi_rvalid),
		.s_axi_rready  (s_axi_rready)
	);

endmodule

//--- rtl/mac_phy_init_seq.sv
/* Bring-up FSM: start-up delay, MAC speed setup, PHY auto-negotiation
   and final MAC configuration writes */
`timescale 1ns/100ps

module mac_phy_init_seq
(
	input  logic       s_axi_aclk,
	input  logic       s_axi_resetn,
	input  logic [1:0] mac_speed,
	cfg_cmd_if.seq     cmd,
	output logic       config_done
);
	import mac_cfg_pkg::*;

	typedef enum logic [4:0] {
		S_START, S_MGMT, S_SPEED, S_STAT, S_GIG, S_ABIL, S_RESTART, S_AN_POLL,
		S_RX_RST, S_TX_RST, S_MGMT2, S_FLOW, S_FILT_EN, S_FILT_CFG, S_UNI0,
		S_UNI1, S_DONE
	} seq_state_e;

	seq_state_e                       state;
	seq_state_e                       next_step;
	mac_speed_e                       speed_q;
	logic [$clog2(STARTUP_DELAY)-1:0] delay_cnt;
	logic                             busy;
	axil_data_t                       stat_q;

	// ----------------------------------------------------------------------
	// Command fields and the step that follows each one
	// ----------------------------------------------------------------------
	always_comb
	begin
		cmd.kind = CMD_MAC_WR;
		cmd.addr = '0;
		cmd.phy_reg = PHY_STAT_REG;
		cmd.wdata = '0;
		next_step = state;
		case (state)
			S_MGMT:
			begin
				cmd.addr = MGMT_CFG_ADDR;
				cmd.wdata = MDC_DIV_WORD;
				next_step = S_SPEED;
			end
			S_SPEED:
			begin
				cmd.addr = SPEED_CFG_ADDR;
				cmd.wdata = {speed_q, 30'd0};
				next_step = S_STAT;
			end
			S_STAT:
			begin
				cmd.kind = CMD_PHY_RD;
				// No PHY on the bus, skip straight to the MAC steps
				next_step = (stat_q[16:0] == PHY_ABSENT_WORD) ? S_RX_RST : S_GIG;
			end
			S_GIG:
			begin
				cmd.kind = CMD_PHY_WR;
				cmd.phy_reg = PHY_GIG_CTRL_REG;
				cmd.wdata = {22'd0, speed_q[1], 9'd0};
				next_step = S_ABIL;
			end
			S_ABIL:
			begin
				cmd.kind = CMD_PHY_WR;
				cmd.phy_reg = PHY_ABILITY_REG;
				cmd.wdata = {23'd0, speed_q == SPEED_100M, 1'b0, speed_q == SPEED_10M, 6'd0};
				next_step = S_RESTART;
			end
			S_RESTART:
			begin
				cmd.kind = CMD_PHY_WR;
				cmd.phy_reg = PHY_CTRL_REG;
				cmd.wdata = PHY_RESTART_WORD;
				next_step = S_AN_POLL;
			end
			S_AN_POLL:
			begin
				cmd.kind = CMD_PHY_RD;
				next_step = stat_q[AN_DONE_BIT] ? S_RX_RST : S_AN_POLL;
			end
			S_RX_RST:
			begin
				cmd.addr = RX_CFG_ADDR;
				cmd.wdata = MAC_RESET_WORD;
				next_step = S_TX_RST;
			end
			S_TX_RST:
			begin
				cmd.addr = TX_CFG_ADDR;
				cmd.wdata = MAC_RESET_WORD;
				next_step = S_MGMT2;
			end
			S_MGMT2:
			begin
				cmd.addr = MGMT_CFG_ADDR;
				cmd.wdata = MDC_DIV_WORD;
				next_step = S_FLOW;
			end
			S_FLOW:
			begin
				cmd.addr = FLOW_CFG_ADDR;
				next_step = S_FILT_EN;
			end
			S_FILT_EN:
			begin
				cmd.addr = FILTER_EN_ADDR;
				cmd.wdata = FILTER_EN_WORD;
				next_step = S_FILT_CFG;
			end
			S_FILT_CFG:
			begin
				// Promiscuous mode off
				cmd.addr = FILTER_CFG_ADDR;
				next_step = S_UNI0;
			end
			S_UNI0:
			begin
				cmd.addr = UNI0_ADDR;
				cmd.wdata = UNI0_WORD;
				next_step = S_UNI1;
			end
			S_UNI1:
			begin
				cmd.addr = UNI1_ADDR;
				cmd.wdata = UNI1_WORD;
				next_step = S_DONE;
			end
			default:
			begin
				next_step = state;
			end
		endcase
	end

	// ----------------------------------------------------------------------
	// Step sequencing with four-phase handshake
	// ----------------------------------------------------------------------
	always_ff @(posedge s_axi_aclk)
	begin
		if (!s_axi_resetn)
		begin
			state <= S_START;
			delay_cnt <= '0;
			busy <= 1'b0;
			cmd.req <= 1'b0;
			speed_q <= mac_speed_e'(mac_speed);
		end
		else
		begin
			case (state)
				S_START:
				begin
					delay_cnt <= delay_cnt + 1'b1;
					if (delay_cnt == STARTUP_DELAY - 1)
					begin
						speed_q <= mac_speed_e'(mac_speed);
						state <= S_MGMT;
					end
				end
				S_DONE:
				begin
					// Parked until the next reset
					busy <= 1'b0;
				end
				default:
				begin
					if (!busy && !cmd.ack)
					begin
						cmd.req <= 1'b1;
						busy <= 1'b1;
					end
					else if (cmd.req && cmd.ack)
						cmd.req <= 1'b0;
					else if (busy && !cmd.req && !cmd.ack)
					begin
						busy <= 1'b0;
						state <= next_step;
					end
				end
			endcase
		end
	end

	// Status word of the last PHY read
	always_ff @(posedge s_axi_aclk)
	begin
		if (cmd.req && cmd.ack)
			stat_q <= cmd.rdata;
	end

	assign config_done = (state == S_DONE);

endmodule

//--- rtl/mdio_cmd_engine.sv
/* Expands PHY commands into MDIO register accesses, passes MAC writes on */
`timescale 1ns/100ps

module mdio_cmd_engine
(
	input  logic       s_axi_aclk,
	input  logic       s_axi_resetn,
	cfg_cmd_if.eng     cmd,
	reg_access_if.eng  acc
);
	import mac_cfg_pkg::*;

	typedef enum logic [2:0] {E_IDLE, E_DATA, E_CTRL, E_POLL, E_ACK} eng_state_e;

	eng_state_e state;
	logic       issued;
	logic [1:0] mdio_op;
	axil_data_t ctrl_word;

	assign mdio_op = (cmd.kind == CMD_PHY_RD) ? MDIO_OP_RD : MDIO_OP_WR;

	// PHY address 28:24, register 20:16, operation 15:14, initiate 11
	assign ctrl_word = {3'd0, PHY_ADDR, 3'd0, cmd.phy_reg, mdio_op, 2'd0, 1'b1, 11'd0};

	always_comb
	begin
		acc.write = (state != E_POLL);
		acc.wdata = (state == E_CTRL) ? ctrl_word : cmd.wdata;
		case (state)
			E_DATA: acc.addr = (cmd.kind == CMD_MAC_WR) ? cmd.addr : MDIO_TX_ADDR;
			E_CTRL: acc.addr = MDIO_CTRL_ADDR;
			E_POLL: acc.addr = MDIO_RX_ADDR;
			default: acc.addr = '0;
		endcase
	end

	// ----------------------------------------------------------------------
	// Access sequencing
	// ----------------------------------------------------------------------
	always_ff @(posedge s_axi_aclk)
	begin
		if (!s_axi_resetn)
		begin
			state <= E_IDLE;
			issued <= 1'b0;
			acc.req <= 1'b0;
			cmd.ack <= 1'b0;
		end
		else
		begin
			case (state)
				E_IDLE:
				begin
					// PHY reads have no data word to load
					if (cmd.req)
						state <= (cmd.kind == CMD_PHY_RD) ? E_CTRL : E_DATA;
				end
				E_ACK:
				begin
					if (!cmd.req)
					begin
						cmd.ack <= 1'b0;
						state <= E_IDLE;
					end
				end
				default:
				begin
					if (!issued)
					begin
						acc.req <= 1'b1;
						issued <= 1'b1;
					end
					else if (acc.req && acc.ack)
						acc.req <= 1'b0;
					else if (!acc.req && !acc.ack)
					begin
						issued <= 1'b0;
						case (state)
							E_DATA:
							begin
								if (cmd.kind == CMD_MAC_WR)
								begin
									cmd.ack <= 1'b1;
									state <= E_ACK;
								end
								else
									state <= E_CTRL;
							end
							E_CTRL: state <= E_POLL;
							default:
							begin
								// Keep polling until the MDIO transfer reports ready
								if (cmd.rdata[MDIO_READY_BIT])
								begin
									cmd.ack <= 1'b1;
									state <= E_ACK;
								end
							end
						endcase
					end
				end
			endcase
		end
	end

	// Last MDIO receive word goes back as the PHY read result
	always_ff @(posedge s_axi_aclk)
	begin
		if (state == E_POLL && acc.req && acc.ack)
			cmd.rdata <= acc.rdata;
	end

endmodule

//--- rtl/reg_access_if.sv
/* Single MAC register access from the MDIO engine to the AXI-Lite master */
`timescale 1ns/100ps

interface reg_access_if;
	import mac_cfg_pkg::*;

	logic       req;
	logic       write;
	axil_addr_t addr;
	axil_data_t wdata;
	logic       ack;
	// Read data, valid while ack is high
	axil_data_t rdata;

	modport eng (
		output req, write, addr, wdata,
		input  ack, rdata
	);

	modport mst (
		input  req, write, addr, wdata,
		output ack, rdata
	);

endinterface

//--- run_sim.sh
#!/bin/sh
# Compile and run the MAC configuration testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mac_cfg_tb -f project.f -o mac_cfg_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/mac_cfg_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
	exit 0
fi
exit 1

//--- verif/mac_cfg_properties.sv
/* Bound assertions on AXI-Lite valid stability, start-up delay and config_done */
`timescale 1ns/100ps

module mac_cfg_properties
(
	input logic                    s_axi_aclk,
	input logic                    s_axi_resetn,
	input logic                    s_axi_awvalid,
	input logic                    s_axi_awready,
	input mac_cfg_pkg::axil_addr_t s_axi_awaddr,
	input logic                    s_axi_wvalid,
	input logic                    s_axi_wready,
	input mac_cfg_pkg::axil_data_t s_axi_wdata,
	input logic                    s_axi_arvalid,
	input logic                    s_axi_arready,
	input mac_cfg_pkg::axil_addr_t s_axi_araddr,
	input logic                    config_done
);
	import mac_cfg_pkg::*;

	int unsigned since_reset;

	// Saturating count of cycles since reset release
	always_ff @(posedge s_axi_aclk)
	begin
		if (!s_axi_resetn)
			since_reset <= 0;
		else if (since_reset < STARTUP_DELAY)
			since_reset <= since_reset + 1;
	end

	assert property (@(posedge s_axi_aclk) disable iff (!s_axi_resetn)
		s_axi_awvalid && !s_axi_awready |=> s_axi_awvalid && $stable(s_axi_awaddr))
		else $error("awvalid or awaddr changed before awready");
	assert property (@(posedge s_axi_aclk) disable iff (!s_axi_resetn)
		s_axi_wvalid && !s_axi_wready |=> s_axi_wvalid && $stable(s_axi_wdata))
		else $error("wvalid or wdata changed before wready");
	assert property (@(posedge s_axi_aclk) disable iff (!s_axi_resetn)
		s_axi_arvalid && !s_axi_arready |=> s_axi_arvalid && $stable(s_axi_araddr))
		else $error("arvalid or araddr changed before arready");
	assert property (@(posedge s_axi_aclk) disable iff (!s_axi_resetn)
		config_done |=> config_done)
		else $error("config_done fell before reset");
	assert property (@(posedge s_axi_aclk) disable iff (!s_axi_resetn)
		since_reset < STARTUP_DELAY |-> !s_axi_awvalid)
		else $error("awvalid inside the start-up delay");

endmodule

bind mac_cfg_top mac_cfg_properties props_i (.*);

//--- verif/mac_cfg_tb.sv
/* Testbench for the MAC configuration master with an AXI-Lite slave model of the MAC,
   a model PHY, the expected write sequence and end-of-run checks */
`timescale 1ns/100ps

module mac_cfg_tb;
	import mac_cfg_pkg::*;

	localparam int NUM_TESTS    = 6;
	localparam int DONE_TIMEOUT = 20000;
	localparam int IDLE_CYCLES  = 50;

	logic       s_axi_aclk = 1'b0;
	logic       s_axi_resetn = 1'b0;
	logic [1:0] mac_speed = 2'd0;
	axil_addr_t s_axi_awaddr;
	logic       s_axi_awvalid;
	logic       s_axi_awready = 1'b0;
	axil_data_t s_axi_wdata;
	logic       s_axi_wvalid;
	logic       s_axi_wready = 1'b0;
	logic [1:0] s_axi_bresp = 2'd0;
	logic       s_axi_bvalid = 1'b0;
	logic       s_axi_bready;
	axil_addr_t s_axi_araddr;
	logic       s_axi_arvalid;
	logic       s_axi_arready = 1'b0;
	axil_data_t s_axi_rdata = '0;
	logic [1:0] s_axi_rresp = 2'd0;
	logic       s_axi_rvalid = 1'b0;
	logic       s_axi_rready;
	logic       config_done;

	integer     seed;
	int         errors;
	int         checks;
	logic       timed_out;
	// Handshakes seen on the last rising edge
	logic       aw_hs = 1'b0;
	logic       w_hs = 1'b0;
	logic       b_hs = 1'b0;
	logic       ar_hs = 1'b0;
	logic       r_hs = 1'b0;
	axil_addr_t aw_addr_q;
	axil_addr_t ar_addr_q;
	axil_data_t w_data_q;
	logic       aw_got;
	logic       w_got;
	logic       b_pend;
	logic       r_pend;
	int         aw_wait;
	int         w_wait;
	int         b_wait;
	int         ar_wait;
	int         r_wait;

	// Model PHY state
	axil_data_t phy_regs [0:31];
	axil_data_t mdio_tx_q;
	logic [15:0] mdio_rx_q;
	int         rx_not_ready;
	int         phy_wr_count;
	int         an_polls;
	int         an_after;
	logic       phy_present;
	logic       restart_seen;
	logic       an_reported;
	axil_addr_t mac_addr_log [$];
	axil_data_t mac_data_log [$];
	logic [6:0] ctrl_log [$];

	mac_cfg_top mac_cfg_top_i (.*);

	initial
	begin
		forever #2 s_axi_aclk = ~s_axi_aclk;
	end

	function automatic int rand_delay(input int span);
		return $unsigned($random(seed)) % span;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got == exp)
		else
		begin
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	function automatic axil_data_t phy_read(input logic [4:0] rg);
		if (!phy_present)
			return 32'h0000_FFFF;
		if (rg != PHY_STAT_REG)
			return phy_regs[rg];
		if (!restart_seen)
			return 32'h0000_7949;
		an_polls++;
		if (an_polls < an_after)
			return 32'h0000_7949;
		an_reported = 1'b1;
		return 32'h0000_7969;
	endfunction

	task automatic model_write(input axil_addr_t addr, input axil_data_t data);
		logic [4:0] rg;
		logic [1:0] op;
		axil_data_t rd_word;
		begin
			rg = data[20:16];
			op = data[15:14];
			if (addr == MDIO_TX_ADDR)
				mdio_tx_q = data;
			else if (addr == MDIO_CTRL_ADDR)
			begin
				check_value("MDIO control PHY address", data[28:24], PHY_ADDR);
				check_value("MDIO control initiate bit", data[11], 1);
				ctrl_log.push_back({op, rg});
				rx_not_ready = rand_delay(3);
				if (op == MDIO_OP_WR)
				begin
					phy_wr_count++;
					if (phy_present)
						phy_regs[rg] = mdio_tx_q;
					if (rg == PHY_CTRL_REG)
						restart_seen = 1'b1;
				end
				else
				begin
					rd_word = phy_read(rg);
					mdio_rx_q = rd_word[15:0];
				end
			end
			else
			begin
				if (addr == RX_CFG_ADDR && phy_present)
				begin
					checks++;
					assert (an_reported)
					else
					begin
						$display("Receiver reset written before the PHY reported auto-negotiation done");
						errors++;
					end
				end
				mac_addr_log.push_back(addr);
				mac_data_log.push_back(data);
			end
		end
	endtask

	function automatic axil_data_t model_read(input axil_addr_t addr);
		if (addr != MDIO_RX_ADDR)
			return '0;
		if (rx_not_ready > 0)
		begin
			rx_not_ready--;
			return {16'd0, mdio_rx_q};
		end
		return {15'd0, 1'b1, mdio_rx_q};
	endfunction

	always @(posedge s_axi_aclk)
	begin
		aw_hs <= s_axi_awvalid && s_axi_awready;
		w_hs <= s_axi_wvalid && s_axi_wready;
		b_hs <= s_axi_bvalid && s_axi_bready;
		ar_hs <= s_axi_arvalid && s_axi_arready;
		r_hs <= s_axi_rvalid && s_axi_rready;
		if (s_axi_awvalid && s_axi_awready)
			aw_addr_q <= s_axi_awaddr;
		if (s_axi_wvalid && s_axi_wready)
			w_data_q <= s_axi_wdata;
		if (s_axi_arvalid && s_axi_arready)
			ar_addr_q <= s_axi_araddr;
		if (s_axi_resetn && s_axi_bvalid && s_axi_bready)
		begin
			checks++;
			assert (!config_done)
			else
			begin
				$display("config_done was high during a write response at %0t", $time);
				errors++;
			end
		end
	end

	// ------------------------------------------------------------------
	// AXI-Lite slave model, driven on the falling edge
	// ------------------------------------------------------------------
	always @(negedge s_axi_aclk)
	begin
		if (!s_axi_resetn)
		begin
			s_axi_awready = 1'b0;
			s_axi_wready = 1'b0;
			s_axi_bvalid = 1'b0;
			s_axi_arready = 1'b0;
			s_axi_rvalid = 1'b0;
			s_axi_rdata = '0;
			aw_got = 1'b0;
			w_got = 1'b0;
			b_pend = 1'b0;
			r_pend = 1'b0;
			aw_wait = 0;
			w_wait = 0;
			b_wait = 0;
			ar_wait = 0;
			r_wait = 0;
		end
		else
		begin
			if (aw_hs)
			begin
				s_axi_awready = 1'b0;
				aw_got = 1'b1;
				aw_wait = rand_delay(4);
			end
			else if (s_axi_awvalid && !s_axi_awready)
			begin
				if (aw_wait == 0)
					s_axi_awready = 1'b1;
				else
					aw_wait--;
			end
			if (w_hs)
			begin
				s_axi_wready = 1'b0;
				w_got = 1'b1;
				w_wait = rand_delay(4);
			end
			else if (s_axi_wvalid && !s_axi_wready)
			begin
				if (w_wait == 0)
					s_axi_wready = 1'b1;
				else
					w_wait--;
			end
			if (aw_got && w_got)
			begin
				aw_got = 1'b0;
				w_got = 1'b0;
				model_write(aw_addr_q, w_data_q);
				b_pend = 1'b1;
			end
			if (b_hs)
				s_axi_bvalid = 1'b0;
			else if (b_pend)
			begin
				if (b_wait == 0)
				begin
					s_axi_bvalid = 1'b1;
					b_pend = 1'b0;
					b_wait = rand_delay(4);
				end
				else
					b_wait--;
			end
			if (ar_hs)
			begin
				// Only the MDIO receive register is ever read
				check_value("s_axi_araddr", ar_addr_q, MDIO_RX_ADDR);
				s_axi_arready = 1'b0;
				s_axi_rdata = model_read(ar_addr_q);
				r_pend = 1'b1;
				ar_wait = rand_delay(4);
			end
			else if (s_axi_arvalid && !s_axi_arready)
			begin
				if (ar_wait == 0)
					s_axi_arready = 1'b1;
				else
					ar_wait--;
			end
			if (r_hs)
			begin
				s_axi_rvalid = 1'b0;
				s_axi_rdata = '0;
			end
			else if (r_pend)
			begin
				if (r_wait == 0)
				begin
					s_axi_rvalid = 1'b1;
					r_pend = 1'b0;
					r_wait = rand_delay(4);
				end
				else
					r_wait--;
			end
		end
	end

	// ------------------------------------------------------------------
	// End-of-run checks against the expected sequence
	// ------------------------------------------------------------------
	task automatic check_results(input logic [1:0] speed);
		axil_addr_t exp_addr [10];
		axil_data_t exp_data [10];
		int n;
		begin
			exp_addr = '{MGMT_CFG_ADDR, SPEED_CFG_ADDR, RX_CFG_ADDR, TX_CFG_ADDR, MGMT_CFG_ADDR,
				FLOW_CFG_ADDR, FILTER_EN_ADDR, FILTER_CFG_ADDR, UNI0_ADDR, UNI1_ADDR};
			exp_data = '{MDC_DIV_WORD, {speed, 30'd0}, MAC_RESET_WORD, MAC_RESET_WORD,
				MDC_DIV_WORD, 32'd0, FILTER_EN_WORD, 32'd0, UNI0_WORD, UNI1_WORD};
			check_value("MAC write count", mac_addr_log.size(), 10);
			for (int i = 0; i < 10 && i < mac_addr_log.size(); i++)
			begin
				check_value($sformatf("s_axi_awaddr of write %0d", i), mac_addr_log[i], exp_addr[i]);
				check_value($sformatf("s_axi_wdata of write %0d", i), mac_data_log[i], exp_data[i]);
			end
			n = phy_present ? 4 + an_after : 1;
			check_value("MDIO control count", ctrl_log.size(), n);
			for (int i = 0; i < n && i < ctrl_log.size(); i++)
			begin
				if (i == 1)
					check_value("MDIO control op/reg", ctrl_log[i], {MDIO_OP_WR, PHY_GIG_CTRL_REG});
				else if (i == 2)
					check_value("MDIO control op/reg", ctrl_log[i], {MDIO_OP_WR, PHY_ABILITY_REG});
				else if (i == 3)
					check_value("MDIO control op/reg", ctrl_log[i], {MDIO_OP_WR, PHY_CTRL_REG});
				else
					check_value("MDIO control op/reg", ctrl_log[i], {MDIO_OP_RD, PHY_STAT_REG});
			end
			if (phy_present)
			begin
				check_value("PHY reg 9 bit 9", phy_regs[9][9], speed[1]);
				check_value("PHY reg 4 bit 8", phy_regs[4][8], speed == SPEED_100M);
				check_value("PHY reg 4 bit 6", phy_regs[4][6], speed == SPEED_10M);
				check_value("PHY reg 0", phy_regs[0], PHY_RESTART_WORD);
			end
			else
				check_value("PHY write count", phy_wr_count, 0);
		end
	endtask

	task automatic run_test(input int t);
		int err_before;
		int cycles;
		logic [1:0] speed;
		begin
			err_before = errors;
			@(negedge s_axi_aclk);
			s_axi_resetn = 1'b0;
			speed = 2'(rand_delay(3));
			mac_speed = speed;
			phy_present = 1'($random(seed) & 1);
			an_after = 1 + rand_delay(4);
			repeat (2) @(negedge s_axi_aclk);
			mac_addr_log.delete();
			mac_data_log.delete();
			ctrl_log.delete();
			for (int i = 0; i < 32; i++)
				phy_regs[i] = '0;
			phy_wr_count = 0;
			an_polls = 0;
			restart_seen = 1'b0;
			an_reported = 1'b0;
			rx_not_ready = 0;
			mdio_rx_q = '0;
			repeat (6) @(negedge s_axi_aclk);
			s_axi_resetn = 1'b1;
			check_value("config_done after reset", config_done, 0);
			cycles = 0;
			while (!config_done && cycles < DONE_TIMEOUT)
			begin
				@(negedge s_axi_aclk);
				cycles++;
			end
			if (!config_done)
			begin
				$display("Test %0d timed out waiting for config_done", t);
				timed_out = 1'b1;
			end
			else
			begin
				check_results(speed);
				repeat (IDLE_CYCLES)
				begin
					@(negedge s_axi_aclk);
					checks++;
					assert (config_done && !s_axi_awvalid && !s_axi_wvalid && !s_axi_arvalid)
					else
					begin
						$display("Bus not idle or config_done dropped after the sequence at %0t",
							$time);
						errors++;
					end
				end
			end
			$display("Test %0d speed %0d PHY %s: %s", t, speed,
				phy_present ? "present" : "absent", (errors == err_before) ? "ok" : "errors");
		end
	endtask

	initial
	begin
		seed = 32'ha14b4429;
		errors = 0;
		checks = 0;
		timed_out = 1'b0;
		for (int t = 0; t < NUM_TESTS && !timed_out; t++)
			run_test(t);
		$display("Tests done: checks %0d, errors %0d", checks, errors);
		if (errors == 0 && !timed_out)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
